/* sources.f */
+incdir+common
common/tag_pkg.sv
common/op_pkg.sv
logic/phys_reg_file.sv
logic/reservation_station.sv
logic/alu_writeback.sv
multiplier/mul_fsm.sv
multiplier/mul_step_counter.sv
multiplier/mul_datapath.sv
logic/ooo_exec_top.sv
dv/ooo_exec_chk.sv
dv/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --assert -f sources.f --top-module tb_top -o tb_top_sim &&
./obj_dir/tb_top_sim || exit 1

/* dv/tb_top.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module tb_clock_gen (
    output logic clk
);
    initial clk = 1'b0;
    always #5 clk = ~clk;
endmodule

module tb_top;
    localparam int N_OPS   = 34;  // 12 + 8 + 6 + 2 + 6
    localparam int TIMEOUT = 40 * N_OPS + 200;

    logic            clk;
    logic            reset;
    tag_pkg::tag_t   src1_tag;
    tag_pkg::tag_t   src2_tag;
    tag_pkg::tag_t   rd_tag;
    op_pkg::alu_op_t alu_op;
    logic            use_imm;
    tag_pkg::word_t  imm;
    logic            alu_dispatch_valid;
    logic            mul_dispatch_valid;
    logic            alu_dispatch_ready;
    logic            mul_dispatch_ready;
    logic            cdb_valid;
    tag_pkg::tag_t   cdb_tag;
    tag_pkg::word_t  cdb_data;

    tag_pkg::word_t        model [`PHYS_REGS];  // value of the latest producer per tag
    logic [`PHYS_REGS-1:0] busy_tag = '0;
    int                    bcast_at [`PHYS_REGS];
    int                    bcast_cnt;
    int                    cycles;
    string                 test_name;
    logic                  mul_full_seen;
    tag_pkg::tag_t         next_tag;

    tb_clock_gen tb_clock_gen_i (.clk(clk));

    ooo_exec_top ooo_exec_top_i (
        .clk, .reset, .src1_tag, .src2_tag, .rd_tag, .alu_op, .use_imm, .imm,
        .alu_dispatch_valid, .mul_dispatch_valid, .alu_dispatch_ready,
        .mul_dispatch_ready, .cdb_valid, .cdb_tag, .cdb_data
    );

    task automatic report_mismatch(input string test, input tag_pkg::tag_t tag,
                                   input tag_pkg::word_t exp, input tag_pkg::word_t act);
        $display("FAIL %s tag %0d expected %h actual %h", test, tag, exp, act);
        $display("Result: FAILED");
        $fatal(1, "wrong broadcast value");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "run stopped");
    endtask

    function automatic tag_pkg::word_t expected_alu(input op_pkg::alu_op_t op,
                                                    input tag_pkg::word_t a,
                                                    input tag_pkg::word_t b);
        case (op)
            op_pkg::ALU_SUB: return a - b;
            op_pkg::ALU_AND: return a & b;
            op_pkg::ALU_OR:  return a | b;
            op_pkg::ALU_XOR: return a ^ b;
            op_pkg::ALU_SLL: return a << b[4:0];
            op_pkg::ALU_SRL: return a >> b[4:0];
            op_pkg::ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:         return a + b;
        endcase
    endfunction

    // random source tag whose value is already out, else tag 0
    function automatic tag_pkg::tag_t pick_ready_tag();
        tag_pkg::tag_t t;
        t = tag_pkg::tag_t'($urandom_range(15, 0));
        return busy_tag[t] ? '0 : t;
    endfunction

    task automatic alloc_tag(output tag_pkg::tag_t t);
        logic found;
        found = 1'b0;
        while (!found) begin
            next_tag = next_tag + 1'b1;
            if (next_tag == '0) @(negedge clk);  // swept all tags, wait for a broadcast
            else found = !busy_tag[next_tag];
        end
        t = next_tag;
    endtask

    // called just after a falling edge, returns after the next one
    task automatic dispatch_op(input logic is_mul, input tag_pkg::tag_t s1,
                               input tag_pkg::tag_t s2, input op_pkg::alu_op_t op,
                               input logic ui, input tag_pkg::word_t im,
                               output tag_pkg::tag_t rd);
        tag_pkg::word_t b;
        alloc_tag(rd);
        b = ui ? im : model[s2];
        model[rd] = is_mul ? model[s1] * model[s2] : expected_alu(op, model[s1], b);
        src1_tag           = s1;
        src2_tag           = s2;
        rd_tag             = rd;
        alu_op             = op;
        use_imm            = ui;
        imm                = im;
        alu_dispatch_valid = !is_mul;
        mul_dispatch_valid = is_mul;
        while (!(is_mul ? mul_dispatch_ready : alu_dispatch_ready)) begin
            if (is_mul) mul_full_seen = 1'b1;
            @(negedge clk);
        end
        @(posedge clk);
        @(negedge clk);
        alu_dispatch_valid = 1'b0;
        mul_dispatch_valid = 1'b0;
    endtask

    task automatic drain();
        while (busy_tag != '0) @(negedge clk);
    endtask

    // scoreboard and tag tracking
    always @(posedge clk) begin
        if (!reset) begin
            if (cdb_valid) begin
                assert (cdb_data == model[cdb_tag])
                    else report_mismatch(test_name, cdb_tag, model[cdb_tag], cdb_data);
                busy_tag[cdb_tag] = 1'b0;
                bcast_at[cdb_tag] = bcast_cnt;
                bcast_cnt++;
            end
            if ((alu_dispatch_valid && alu_dispatch_ready) ||
                (mul_dispatch_valid && mul_dispatch_ready)) busy_tag[rd_tag] = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) report_failure("timeout: ops did not complete in time");
    end

    initial begin
        tag_pkg::tag_t rd;
        tag_pkg::tag_t prev;
        tag_pkg::tag_t mul_rd;
        void'($urandom(32'h043823e2));
        reset              = 1'b1;
        src1_tag           = '0;
        src2_tag           = '0;
        rd_tag             = '0;
        alu_op             = op_pkg::ALU_ADD;
        use_imm            = 1'b0;
        imm                = '0;
        alu_dispatch_valid = 1'b0;
        mul_dispatch_valid = 1'b0;
        mul_full_seen      = 1'b0;
        next_tag           = '0;
        test_name          = "reset";
        for (int i = 0; i < `PHYS_REGS; i++) model[i] = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_name = "alu_random";
        for (int i = 0; i < 12; i++) begin
            if (i < 4) dispatch_op(1'b0, pick_ready_tag(), '0, op_pkg::ALU_ADD, 1'b1,
                                   $urandom(), rd);  // seed some values
            else dispatch_op(1'b0, pick_ready_tag(), pick_ready_tag(),
                             op_pkg::alu_op_t'($urandom_range(7, 0)),
                             1'($urandom_range(1, 0)), $urandom(), rd);
        end
        drain();

        test_name = "alu_chain";
        prev = pick_ready_tag();
        for (int i = 0; i < 8; i++) begin
            dispatch_op(1'b0, prev, pick_ready_tag(), op_pkg::alu_op_t'($urandom_range(7, 0)),
                        1'(i % 2), $urandom(), rd);
            prev = rd;
        end
        drain();

        test_name = "mul_random";
        for (int i = 0; i < 6; i++) begin
            dispatch_op(1'b1, pick_ready_tag(), pick_ready_tag(), op_pkg::ALU_ADD, 1'b0,
                        '0, rd);
        end
        drain();

        test_name = "alu_passes_mul";
        dispatch_op(1'b1, pick_ready_tag(), pick_ready_tag(), op_pkg::ALU_ADD, 1'b0, '0, mul_rd);
        dispatch_op(1'b0, pick_ready_tag(), '0, op_pkg::ALU_XOR, 1'b1, $urandom(), rd);
        drain();
        assert (bcast_at[rd] < bcast_at[mul_rd])
            else report_failure("ALU op was not broadcast before the earlier multiply");

        test_name     = "mul_station_full";
        mul_full_seen = 1'b0;
        dispatch_op(1'b1, pick_ready_tag(), pick_ready_tag(), op_pkg::ALU_ADD, 1'b0, '0, mul_rd);
        for (int i = 0; i < 5; i++) begin
            dispatch_op(1'b1, mul_rd, pick_ready_tag(), op_pkg::ALU_ADD, 1'b0, '0, rd);
        end
        drain();
        assert (mul_full_seen)
            else report_failure("mul_dispatch_ready never fell with the station full");

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* dv/ooo_exec_chk.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module ooo_exec_chk (
    input logic           clk,
    input logic           reset,
    input tag_pkg::tag_t  rd_tag,
    input logic           alu_dispatch_valid,
    input logic           alu_dispatch_ready,
    input logic           mul_dispatch_valid,
    input logic           mul_dispatch_ready,
    input logic           cdb_valid,
    input tag_pkg::tag_t  cdb_tag
);
    logic [`PHYS_REGS-1:0] pending_q;  // tags dispatched and not yet broadcast
    logic                  alloc;

    assign alloc = (alu_dispatch_valid && alu_dispatch_ready) ||
                   (mul_dispatch_valid && mul_dispatch_ready);

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_q <= '0;
        end else begin
            if (cdb_valid) pending_q[cdb_tag] <= 1'b0;
            if (alloc) pending_q[rd_tag] <= 1'b1;
        end
    end

    a_cdb_idle_after_reset: assert property (@(posedge clk) reset |=> !cdb_valid)
        else $error("cdb_valid high right after reset");

    a_one_dispatch: assert property (@(posedge clk) disable iff (reset)
        !(alu_dispatch_valid && mul_dispatch_valid))
        else $error("both dispatch valids high in one cycle");

    a_tag_nonzero: assert property (@(posedge clk) disable iff (reset)
        cdb_valid |-> cdb_tag != '0)
        else $error("broadcast on tag 0");

    a_tag_pending: assert property (@(posedge clk) disable iff (reset)
        cdb_valid |-> pending_q[cdb_tag])
        else $error("tag %0d broadcast with no dispatch pending", cdb_tag);

endmodule

bind ooo_exec_top ooo_exec_chk ooo_exec_chk_i (
    .clk(clk), .reset(reset), .rd_tag(rd_tag),
    .alu_dispatch_valid(alu_dispatch_valid), .alu_dispatch_ready(alu_dispatch_ready),
    .mul_dispatch_valid(mul_dispatch_valid), .mul_dispatch_ready(mul_dispatch_ready),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag)
);

/* logic/ooo_exec_top.sv */
`timescale 1ns/1ps

module ooo_exec_top (
    input  logic            clk,
    input  logic            reset,
    input  tag_pkg::tag_t   src1_tag,
    input  tag_pkg::tag_t   src2_tag,
    input  tag_pkg::tag_t   rd_tag,
    input  op_pkg::alu_op_t alu_op,
    input  logic            use_imm,
    input  tag_pkg::word_t  imm,
    input  logic            alu_dispatch_valid,
    input  logic            mul_dispatch_valid,
    output logic            alu_dispatch_ready,
    output logic            mul_dispatch_ready,
    output logic            cdb_valid,
    output tag_pkg::tag_t   cdb_tag,
    output tag_pkg::word_t  cdb_data
);
    tag_pkg::word_t       src1_value, src2_value;
    logic                 src1_ready, src2_ready;
    logic                 alloc;
    op_pkg::alu_payload_t alu_payload, alu_issue_payload;
    op_pkg::mul_payload_t mul_payload, mul_issue_payload;
    logic                 alu_issue_valid, alu_issue_ready;
    tag_pkg::word_t       alu_issue_a, alu_issue_b;
    logic                 mul_issue_valid, mul_ready;
    tag_pkg::word_t       mul_issue_a, mul_issue_b;
    logic                 mul_busy, mul_load, mul_done, mul_ack, last_step;
    tag_pkg::word_t       mul_product;
    tag_pkg::tag_t        mul_tag;

    assign alloc = (alu_dispatch_valid && alu_dispatch_ready) ||
                   (mul_dispatch_valid && mul_dispatch_ready);
    assign alu_payload = '{rd: rd_tag, op: alu_op, use_imm: use_imm, imm: imm};
    assign mul_payload = '{rd: rd_tag};

    phys_reg_file phys_reg_file_i (
        .clk, .reset, .src1_tag, .src2_tag, .rd_tag, .alloc,
        .cdb_valid, .cdb_tag, .cdb_data,
        .src1_value, .src2_value, .src1_ready, .src2_ready
    );

    reservation_station #(.payload_t(op_pkg::alu_payload_t)) alu_station (
        .clk, .reset, .dispatch_valid(alu_dispatch_valid), .payload(alu_payload),
        .src1_tag, .src2_tag, .src1_value, .src2_value, .src1_ready, .src2_ready,
        .cdb_valid, .cdb_tag, .cdb_data, .issue_ready(alu_issue_ready),
        .dispatch_ready(alu_dispatch_ready), .issue_valid(alu_issue_valid),
        .issue_payload(alu_issue_payload), .issue_a(alu_issue_a), .issue_b(alu_issue_b)
    );

    reservation_station #(.payload_t(op_pkg::mul_payload_t)) mul_station (
        .clk, .reset, .dispatch_valid(mul_dispatch_valid), .payload(mul_payload),
        .src1_tag, .src2_tag, .src1_value, .src2_value, .src1_ready, .src2_ready,
        .cdb_valid, .cdb_tag, .cdb_data, .issue_ready(mul_ready),
        .dispatch_ready(mul_dispatch_ready), .issue_valid(mul_issue_valid),
        .issue_payload(mul_issue_payload), .issue_a(mul_issue_a), .issue_b(mul_issue_b)
    );

    alu_writeback alu_writeback_i (
        .clk, .reset, .issue_valid(alu_issue_valid), .issue_payload(alu_issue_payload),
        .issue_a(alu_issue_a), .issue_b(alu_issue_b),
        .mul_done, .mul_tag, .mul_product,
        .issue_ready(alu_issue_ready), .mul_ack, .cdb_valid, .cdb_tag, .cdb_data
    );

    mul_fsm mul_fsm_i (
        .clk, .reset, .start(mul_issue_valid), .last_step, .ack(mul_ack),
        .ready(mul_ready), .busy(mul_busy), .load(mul_load), .done(mul_done)
    );

    mul_step_counter mul_step_counter_i (
        .clk, .reset, .load(mul_load), .busy(mul_busy), .last_step
    );

    mul_datapath mul_datapath_i (
        .clk, .reset, .load(mul_load), .busy(mul_busy),
        .a(mul_issue_a), .b(mul_issue_b), .tag(mul_issue_payload.rd),
        .product(mul_product), .product_tag(mul_tag)
    );

endmodule

/* multiplier/mul_datapath.sv */
`timescale 1ns/1ps

module mul_datapath (
    input  logic           clk,
    input  logic           reset,
    input  logic           load,
    input  logic           busy,
    input  tag_pkg::word_t a,
    input  tag_pkg::word_t b,
    input  tag_pkg::tag_t  tag,
    output tag_pkg::word_t product,
    output tag_pkg::tag_t  product_tag
);
    tag_pkg::word_t mcand_q;
    tag_pkg::word_t mplier_q;
    tag_pkg::word_t acc_q;

    always_ff @(posedge clk) begin
        if (reset) acc_q <= '0;
        else if (load) acc_q <= '0;
        else if (busy && mplier_q[0]) acc_q <= acc_q + mcand_q;  // low word only
        if (load) begin
            mcand_q     <= a;
            mplier_q    <= b;
            product_tag <= tag;
        end else if (busy) begin
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign product = acc_q;

endmodule

/* multiplier/mul_step_counter.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module mul_step_counter (
    input  logic clk,
    input  logic reset,
    input  logic load,
    input  logic busy,
    output logic last_step
);
    localparam int CNT_W = $clog2(`MUL_STEPS);

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk) begin
        if (reset) count_q <= '0;
        else if (load) count_q <= CNT_W'(`MUL_STEPS - 1);
        else if (busy) count_q <= count_q - 1'b1;
    end

    assign last_step = count_q == '0;

endmodule

/* multiplier/mul_fsm.sv */
`timescale 1ns/1ps

module mul_fsm (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic last_step,
    input  logic ack,
    output logic ready,
    output logic busy,
    output logic load,
    output logic done
);
    typedef enum logic [1:0] {IDLE, BUSY, DONE} state_t;

    state_t state_q;
    state_t state_n;

    always_comb begin
        state_n = state_q;
        unique case (state_q)
            IDLE:    if (load) state_n = BUSY;
            BUSY:    if (last_step) state_n = DONE;
            default: if (ack) state_n = IDLE;  // product held until taken
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) state_q <= IDLE;
        else state_q <= state_n;
    end

    assign ready = state_q == IDLE;
    assign busy  = state_q == BUSY;
    assign done  = state_q == DONE;
    assign load  = start && ready;

endmodule

/* logic/alu_writeback.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module alu_writeback (
    input  logic                clk,
    input  logic                reset,
    input  logic                issue_valid,
    input  op_pkg::alu_payload_t issue_payload,
    input  tag_pkg::word_t      issue_a,
    input  tag_pkg::word_t      issue_b,
    input  logic                mul_done,
    input  tag_pkg::tag_t       mul_tag,
    input  tag_pkg::word_t      mul_product,
    output logic                issue_ready,
    output logic                mul_ack,
    output logic                cdb_valid,
    output tag_pkg::tag_t       cdb_tag,
    output tag_pkg::word_t      cdb_data
);
    localparam int SHAMT_W = $clog2(`XLEN);

    tag_pkg::word_t opb;
    tag_pkg::word_t result;
    tag_pkg::cdb_t  hold_q;
    logic           hold_valid_q;
    logic           alu_grant;

    assign opb = issue_payload.use_imm ? issue_payload.imm : issue_b;

    always_comb begin
        unique case (issue_payload.op)
            op_pkg::ALU_ADD: result = issue_a + opb;
            op_pkg::ALU_SUB: result = issue_a - opb;
            op_pkg::ALU_AND: result = issue_a & opb;
            op_pkg::ALU_OR:  result = issue_a | opb;
            op_pkg::ALU_XOR: result = issue_a ^ opb;
            op_pkg::ALU_SLL: result = issue_a << opb[SHAMT_W-1:0];
            op_pkg::ALU_SRL: result = issue_a >> opb[SHAMT_W-1:0];
            default:         result = tag_pkg::word_t'($signed(issue_a) < $signed(opb));
        endcase
    end

    // multiply result owns the bus whenever it is waiting
    assign mul_ack     = mul_done;
    assign alu_grant   = hold_valid_q && !mul_done;
    assign issue_ready = !hold_valid_q || alu_grant;

    always_ff @(posedge clk) begin
        if (reset) hold_valid_q <= 1'b0;
        else if (issue_ready) hold_valid_q <= issue_valid;
        if (issue_valid && issue_ready) hold_q <= '{tag: issue_payload.rd, data: result};
    end

    assign cdb_valid = mul_done || hold_valid_q;
    assign cdb_tag   = mul_done ? mul_tag : hold_q.tag;
    assign cdb_data  = mul_done ? mul_product : hold_q.data;

endmodule

/* logic/reservation_station.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module reservation_station #(
    parameter type payload_t = logic
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           dispatch_valid,
    input  payload_t       payload,
    input  tag_pkg::tag_t  src1_tag,
    input  tag_pkg::tag_t  src2_tag,
    input  tag_pkg::word_t src1_value,
    input  tag_pkg::word_t src2_value,
    input  logic           src1_ready,
    input  logic           src2_ready,
    input  logic           cdb_valid,
    input  tag_pkg::tag_t  cdb_tag,
    input  tag_pkg::word_t cdb_data,
    input  logic           issue_ready,
    output logic           dispatch_ready,
    output logic           issue_valid,
    output payload_t       issue_payload,
    output tag_pkg::word_t issue_a,
    output tag_pkg::word_t issue_b
);
    localparam int IDX_W = $clog2(`RS_DEPTH);

    typedef struct packed {
        payload_t       pay;
        tag_pkg::tag_t  tag1;
        tag_pkg::tag_t  tag2;
        tag_pkg::word_t val1;
        tag_pkg::word_t val2;
        logic           rdy1;
        logic           rdy2;
    } entry_t;

    // entry 0 is the oldest, the queue collapses on issue
    entry_t               ent_q [`RS_DEPTH];
    entry_t               ent_n [`RS_DEPTH];
    logic [`RS_DEPTH-1:0] used_q;
    logic [`RS_DEPTH-1:0] used_n;
    logic [IDX_W-1:0]     sel;
    logic [IDX_W-1:0]     slot;
    logic                 issue_fire;

    assign dispatch_ready = !used_q[`RS_DEPTH-1];
    assign issue_fire     = issue_valid && issue_ready;
    assign issue_payload  = ent_q[sel].pay;
    assign issue_a        = ent_q[sel].val1;
    assign issue_b        = ent_q[sel].val2;

    always_comb begin
        sel         = '0;
        issue_valid = 1'b0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (used_q[i] && ent_q[i].rdy1 && ent_q[i].rdy2) begin
                sel         = IDX_W'(i);
                issue_valid = 1'b1;
            end
        end
    end

    always_comb begin
        used_n = used_q;
        ent_n  = ent_q;
        slot   = '0;
        if (issue_fire) begin
            for (int i = 0; i < `RS_DEPTH - 1; i++) begin
                if (i >= int'(sel)) begin
                    used_n[i] = used_q[i+1];
                    ent_n[i]  = ent_q[i+1];
                end
            end
            used_n[`RS_DEPTH-1] = 1'b0;
        end
        for (int i = 0; i < `RS_DEPTH; i++) begin  // wakeup
            if (cdb_valid && !ent_n[i].rdy1 && ent_n[i].tag1 == cdb_tag) begin
                ent_n[i].rdy1 = 1'b1;
                ent_n[i].val1 = cdb_data;
            end
            if (cdb_valid && !ent_n[i].rdy2 && ent_n[i].tag2 == cdb_tag) begin
                ent_n[i].rdy2 = 1'b1;
                ent_n[i].val2 = cdb_data;
            end
        end
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!used_n[i]) slot = IDX_W'(i);  // lowest free
        end
        if (dispatch_valid && dispatch_ready) begin
            used_n[slot] = 1'b1;
            ent_n[slot]  = '{pay: payload, tag1: src1_tag, tag2: src2_tag,
                             val1: src1_value, val2: src2_value,
                             rdy1: src1_ready, rdy2: src2_ready};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) used_q <= '0;
        else used_q <= used_n;
        ent_q <= ent_n;
    end

endmodule

/* logic/phys_reg_file.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module phys_reg_file (
    input  logic           clk,
    input  logic           reset,
    input  tag_pkg::tag_t  src1_tag,
    input  tag_pkg::tag_t  src2_tag,
    input  tag_pkg::tag_t  rd_tag,
    input  logic           alloc,
    input  logic           cdb_valid,
    input  tag_pkg::tag_t  cdb_tag,
    input  tag_pkg::word_t cdb_data,
    output tag_pkg::word_t src1_value,
    output tag_pkg::word_t src2_value,
    output logic           src1_ready,
    output logic           src2_ready
);
    tag_pkg::word_t         regs_q [`PHYS_REGS];
    logic [`PHYS_REGS-1:0]  ready_q;
    logic                   src1_hit;
    logic                   src2_hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            ready_q <= '1;
            for (int i = 0; i < `PHYS_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (cdb_valid && cdb_tag != '0) begin
                regs_q[cdb_tag]  <= cdb_data;
                ready_q[cdb_tag] <= 1'b1;
            end
            if (alloc && rd_tag != '0) ready_q[rd_tag] <= 1'b0;  // new producer wins
        end
    end

    // same-cycle broadcast bypasses the array
    assign src1_hit   = cdb_valid && cdb_tag == src1_tag;
    assign src2_hit   = cdb_valid && cdb_tag == src2_tag;
    assign src1_value = (src1_tag == '0) ? '0 : src1_hit ? cdb_data : regs_q[src1_tag];
    assign src2_value = (src2_tag == '0) ? '0 : src2_hit ? cdb_data : regs_q[src2_tag];
    assign src1_ready = (src1_tag == '0) || src1_hit || ready_q[src1_tag];
    assign src2_ready = (src2_tag == '0) || src2_hit || ready_q[src2_tag];

endmodule

/* common/op_pkg.sv */
package op_pkg;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7   // signed compare
    } alu_op_t;

    typedef struct packed {
        tag_pkg::tag_t  rd;
        alu_op_t        op;
        logic           use_imm;
        tag_pkg::word_t imm;
    } alu_payload_t;

    // multiply carries only where the product goes
    typedef struct packed {
        tag_pkg::tag_t rd;
    } mul_payload_t;

endpackage

/* common/tag_pkg.sv */
`include "ooo_defines.svh"

package tag_pkg;

    typedef logic [`TAG_W-1:0] tag_t;

    typedef logic [`XLEN-1:0] word_t;

    // one result on the common data bus
    typedef struct packed {
        tag_t  tag;
        word_t data;
    } cdb_t;

endpackage

/* common/ooo_defines.svh */
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

`define XLEN      32
`define PHYS_REGS 16
`define TAG_W     4  // log2 of PHYS_REGS
`define RS_DEPTH  4
`define MUL_STEPS 32

`endif
